//--- source/mem_settings.svh
// Size settings of the local memory.
// MEM_ADDR_WIDTH counts word-address bits, so the RAM holds 2**MEM_ADDR_WIDTH words.
// MEM_DATA_WIDTH must stay a multiple of 8 so that the byte enables line up.

`ifndef MEM_SETTINGS_SVH
`define MEM_SETTINGS_SVH

// 1024 words by default.
`define MEM_ADDR_WIDTH 10

`define MEM_DATA_WIDTH 32

`endif

//--- source/riscv_pkg.sv
// Architectural types shared by the core and its local memory.
// The data memory operation codes follow the core's decoder and are not
// meant to be reordered.

package riscv_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // words
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // rv32, data and byte addresses.
    typedef logic [31:0] word_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // data memory operations
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // One code per cycle, fixed latency and no handshake.
    // Loads return their result in the following cycle.
    typedef enum logic [3:0] {
        LOAD_STORE_NONE    = 4'd0,  // port idle.

        // loads, sign extended.
        LOAD_WORD          = 4'd1,
        LOAD_HALF          = 4'd2,
        LOAD_BYTE          = 4'd3,

        // loads, zero extended.
        LOAD_HALF_UNSIGNED = 4'd4,
        LOAD_BYTE_UNSIGNED = 4'd5,

        // stores, naturally aligned.
        STORE_WORD         = 4'd6,
        STORE_HALF         = 4'd7,
        STORE_BYTE         = 4'd8
    } mem_op_t;

endpackage

//--- source/mem_pkg.sv
// Types of the memory subsystem, sized from the memory settings header.
// A RAM address is a word address, without the two byte-offset bits.

`include "mem_settings.svh"

package mem_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // ram side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // word address into the array.
    typedef logic [`MEM_ADDR_WIDTH-1:0] ram_addr_t;

    // one write enable per byte lane.
    typedef logic [`MEM_DATA_WIDTH/8-1:0] byte_en_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // lane steering
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Byte offset inside a word, taken from the low address bits.
    typedef logic [$clog2(`MEM_DATA_WIDTH/8)-1:0] lane_t;

endpackage

//--- source/ram_port_if.sv
// One port of the block RAM.
// Fixed one-cycle read, no ready. rdata holds while en is low.
// A write and a read on the same edge return the old word.

interface ram_port_if;

    logic                en;     // access this cycle.
    mem_pkg::byte_en_t   we;     // byte lanes to write.
    mem_pkg::ram_addr_t  addr;
    riscv_pkg::word_t    wdata;
    riscv_pkg::word_t    rdata;  // valid the cycle after en.

    // side that issues requests.
    modport requester (
        output en,
        output we,
        output addr,
        output wdata,
        input  rdata
    );

    // side that owns the storage.
    modport memory (
        input  en,
        input  we,
        input  addr,
        input  wdata,
        output rdata
    );

endinterface

//--- source/dual_port_bram.sv
// True dual-port RAM with byte write enables and registered reads.
// Read-before-write on each port. No reset and no initial contents.
// Both ports writing one word on the same edge is not resolved in a
// defined way by the hardware. Port b wins here and an assertion fires.

`include "mem_settings.svh"

module dual_port_bram (
    input logic        clk,
    ram_port_if.memory a,
    ram_port_if.memory b
);

    localparam int DEPTH     = 2 ** `MEM_ADDR_WIDTH;
    localparam int NUM_BYTES = $bits(mem_pkg::byte_en_t);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // storage
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    logic [NUM_BYTES-1:0][7:0] mem_q [DEPTH];

    always_ff @(posedge clk) begin
        // port a.
        if (a.en) begin
            a.rdata <= mem_q[a.addr];  // old word.
            for (int i = 0; i < NUM_BYTES; i++) begin
                if (a.we[i]) begin
                    mem_q[a.addr][i] <= a.wdata[8*i +: 8];
                end
            end
        end

        // port b.
        if (b.en) begin
            b.rdata <= mem_q[b.addr];
            for (int i = 0; i < NUM_BYTES; i++) begin
                if (b.we[i]) begin
                    mem_q[b.addr][i] <= b.wdata[8*i +: 8];
                end
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // both requesters writing the same word.
    a_no_write_collision: assert property (
        @(posedge clk)
        !(a.en && (|a.we) && b.en && (|b.we) && (a.addr == b.addr))
    ) else $error("both RAM ports write address %0h in one cycle", a.addr);

endmodule

//--- source/data_lane_unit.sv
// Data side of the local memory.
// Accesses must be naturally aligned; misaligned ones are flagged by
// assertions only and wrap inside the word.
// Load data comes back the cycle after the request.

`include "mem_settings.svh"

module data_lane_unit (
    input  logic                clk,
    input  logic                rst_n,
    input  riscv_pkg::mem_op_t  dmem_op,
    input  riscv_pkg::word_t    dmem_addr,
    input  riscv_pkg::word_t    dmem_wdata,
    output riscv_pkg::word_t    dmem_rdata,
    ram_port_if.requester       ram
);

    mem_pkg::lane_t      lane;
    logic                is_load;
    riscv_pkg::mem_op_t  load_op_q;  // load kind beside the RAM read.
    mem_pkg::lane_t      lane_q;
    riscv_pkg::word_t    shifted;

    assign lane    = dmem_addr[1:0];
    assign is_load = dmem_op inside {
        riscv_pkg::LOAD_WORD,
        riscv_pkg::LOAD_HALF,
        riscv_pkg::LOAD_BYTE,
        riscv_pkg::LOAD_HALF_UNSIGNED,
        riscv_pkg::LOAD_BYTE_UNSIGNED
    };

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // request
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign ram.en   = dmem_op != riscv_pkg::LOAD_STORE_NONE;
    assign ram.addr = dmem_addr[`MEM_ADDR_WIDTH+1:2];

    // Store data is moved up to its lane; the enables pick the bytes.
    always_comb begin
        ram.wdata = dmem_wdata << {lane, 3'b000};
        unique case (dmem_op)
            riscv_pkg::STORE_WORD: ram.we = 4'b1111;
            riscv_pkg::STORE_HALF: ram.we = lane[1] ? 4'b1100 : 4'b0011;
            riscv_pkg::STORE_BYTE: ram.we = 4'b0001 << lane;
            default:               ram.we = 4'b0000;  // loads read only.
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // load return
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            load_op_q <= riscv_pkg::LOAD_STORE_NONE;
        end else begin
            load_op_q <= is_load ? dmem_op : riscv_pkg::LOAD_STORE_NONE;
        end
    end

    always_ff @(posedge clk) begin
        lane_q <= lane;
    end

    // addressed byte or half down to bit 0.
    assign shifted = ram.rdata >> {lane_q, 3'b000};

    always_comb begin
        unique case (load_op_q)
            riscv_pkg::LOAD_WORD:
                dmem_rdata = ram.rdata;
            riscv_pkg::LOAD_HALF:
                dmem_rdata = {{16{shifted[15]}}, shifted[15:0]};
            riscv_pkg::LOAD_BYTE:
                dmem_rdata = {{24{shifted[7]}}, shifted[7:0]};
            riscv_pkg::LOAD_HALF_UNSIGNED:
                dmem_rdata = {16'h0000, shifted[15:0]};
            riscv_pkg::LOAD_BYTE_UNSIGNED:
                dmem_rdata = {24'h000000, shifted[7:0]};
            default:
                dmem_rdata = ram.rdata;  // not a load, value unused.
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // alignment checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    a_half_aligned: assert property (
        @(posedge clk) disable iff (!rst_n)
        (dmem_op inside {riscv_pkg::LOAD_HALF, riscv_pkg::LOAD_HALF_UNSIGNED,
                         riscv_pkg::STORE_HALF}) |-> !dmem_addr[0]
    ) else $error("misaligned halfword access at %h", dmem_addr);

    a_word_aligned: assert property (
        @(posedge clk) disable iff (!rst_n)
        (dmem_op inside {riscv_pkg::LOAD_WORD, riscv_pkg::STORE_WORD})
            |-> (dmem_addr[1:0] == 2'b00)
    ) else $error("misaligned word access at %h", dmem_addr);

endmodule

//--- source/fetch_port.sv
// Instruction side of the local memory. Reads one word every cycle.
// A misaligned address still returns the word it falls in; the error
// flag comes with that word.

`include "mem_settings.svh"

module fetch_port (
    input  logic              clk,
    input  logic              rst_n,
    input  riscv_pkg::word_t  imem_addr,
    output riscv_pkg::word_t  imem_rdata,
    output logic              imem_error,
    ram_port_if.requester     ram
);

    logic error_q;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // read request
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign ram.en    = 1'b1;   // fetch never stalls.
    assign ram.we    = '0;
    assign ram.wdata = '0;
    assign ram.addr  = imem_addr[`MEM_ADDR_WIDTH+1:2];

    assign imem_rdata = ram.rdata;

    // flag travels with the read word.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            error_q <= 1'b0;
        end else begin
            error_q <= |imem_addr[1:0];
        end
    end

    assign imem_error = error_q;

    // no stale flag out of reset.
    a_error_clear_after_reset: assert property (
        @(posedge clk) !rst_n |=> !imem_error
    ) else $error("imem_error set in the cycle after reset");

endmodule

//--- source/memory.sv
// Local memory of the core: one block RAM shared by data and fetch.
// Data accesses must be naturally aligned. Both ports have a fixed
// one-cycle latency and no back-pressure.
// Only the low word-address bits are decoded; higher bits alias.

module memory (
    input  logic                clk,
    input  logic                rst_n,

    // data port.
    input  riscv_pkg::mem_op_t  dmem_op,
    input  riscv_pkg::word_t    dmem_addr,
    input  riscv_pkg::word_t    dmem_wdata,
    output riscv_pkg::word_t    dmem_rdata,

    // instruction port.
    input  riscv_pkg::word_t    imem_addr,
    output riscv_pkg::word_t    imem_rdata,
    output logic                imem_error
);

    ram_port_if dport ();
    ram_port_if iport ();

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // request paths
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    data_lane_unit u_data_lane_unit (
        .clk        (clk),
        .rst_n      (rst_n),
        .dmem_op    (dmem_op),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_rdata (dmem_rdata),
        .ram        (dport.requester)
    );

    fetch_port u_fetch_port (
        .clk        (clk),
        .rst_n      (rst_n),
        .imem_addr  (imem_addr),
        .imem_rdata (imem_rdata),
        .imem_error (imem_error),
        .ram        (iport.requester)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // shared storage
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // port a data, port b fetch.
    dual_port_bram u_dual_port_bram (
        .clk (clk),
        .a   (dport.memory),
        .b   (iport.memory)
    );

endmodule

//--- tb/memory_tests.svh
// Tasks of the memory testbench, included inside tb_memory.
// Every step also fetches, so the instruction port is checked alongside
// all data traffic once the RAM contents are known.

`ifndef MEMORY_TESTS_SVH
`define MEMORY_TESTS_SVH

task automatic check_equal(input riscv_pkg::word_t actual, input riscv_pkg::word_t expected,
                           input string what);
    if (actual !== expected) begin
        $display("[FAIL] %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
        $display("sim failed");
        $fatal(1, "value mismatch");
    end
endtask

task automatic wait_reset_release();
    int cycles;
    cycles = 0;
    while (rst_n !== 1'b1) begin
        if (cycles == 20) begin
            $display("reset was not released within 20 cycles");
            $display("sim failed");
            $fatal(1, "reset timeout");
        end
        @(negedge clk);
        cycles++;
    end
endtask

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// reference model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

function automatic int word_index(input riscv_pkg::word_t addr);
    return int'(addr[`MEM_ADDR_WIDTH+1:2]);
endfunction

function automatic logic is_load(input riscv_pkg::mem_op_t op);
    return op inside {riscv_pkg::LOAD_WORD, riscv_pkg::LOAD_HALF, riscv_pkg::LOAD_BYTE,
                      riscv_pkg::LOAD_HALF_UNSIGNED, riscv_pkg::LOAD_BYTE_UNSIGNED};
endfunction

function automatic riscv_pkg::word_t predict_load(input riscv_pkg::mem_op_t op,
                                                  input riscv_pkg::word_t addr);
    riscv_pkg::word_t w;
    logic [15:0]      h;
    logic [7:0]       b;
    w = model_mem[word_index(addr)];
    h = w[16*addr[1] +: 16];
    b = w[8*addr[1:0] +: 8];
    case (op)
        riscv_pkg::LOAD_HALF:          return {{16{h[15]}}, h};
        riscv_pkg::LOAD_BYTE:          return {{24{b[7]}}, b};
        riscv_pkg::LOAD_HALF_UNSIGNED: return {16'h0, h};
        riscv_pkg::LOAD_BYTE_UNSIGNED: return {24'h0, b};
        default:                       return w;
    endcase
endfunction

function automatic void apply_store(input riscv_pkg::mem_op_t op, input riscv_pkg::word_t addr,
                                    input riscv_pkg::word_t wdata);
    case (op)
        riscv_pkg::STORE_WORD: model_mem[word_index(addr)] = wdata;
        riscv_pkg::STORE_HALF: model_mem[word_index(addr)][16*addr[1] +: 16] = wdata[15:0];
        riscv_pkg::STORE_BYTE: model_mem[word_index(addr)][8*addr[1:0] +: 8] = wdata[7:0];
        default: ;
    endcase
endfunction

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bus driving
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// One cycle on both ports. Results of the previous cycle are checked at
// the falling edge; the fetch expectation is taken before this store lands.
task automatic step(input riscv_pkg::mem_op_t op, input riscv_pkg::word_t addr,
                    input riscv_pkg::word_t wdata, input riscv_pkg::word_t iaddr);
    @(posedge clk);
    dmem_op    <= op;
    dmem_addr  <= addr;
    dmem_wdata <= wdata;
    imem_addr  <= iaddr;
    @(negedge clk);
    if (load_pending) begin
        check_equal(dmem_rdata, load_expect, load_what);
    end
    if (fetch_pending) begin
        check_equal(imem_error, error_expect, {fetch_what, " error flag"});
        if (fetch_data_valid) begin
            check_equal(imem_rdata, fetch_expect, fetch_what);
        end
    end
    load_pending     = is_load(op);
    load_expect      = predict_load(op, addr);
    load_what        = $sformatf("%s at %h", op.name(), addr);
    fetch_pending    = 1'b1;
    fetch_data_valid = memory_known;
    fetch_expect     = model_mem[word_index(iaddr)];  // read before write.
    error_expect     = (iaddr % 4) != 0;
    fetch_what       = $sformatf("fetch at %h", iaddr);
    apply_store(op, addr, wdata);
endtask

function automatic riscv_pkg::word_t rand_word_addr();
    return take_bits(`MEM_ADDR_WIDTH) << 2;
endfunction

function automatic riscv_pkg::word_t rand_fetch_addr();
    return take_bits(`MEM_ADDR_WIDTH + 2);  // low bits too.
endfunction

task automatic preload_memory();
    for (int i = 0; i < DEPTH; i++) begin
        step(riscv_pkg::STORE_WORD, i * 4, take_bits(32), rand_fetch_addr());
    end
    memory_known = 1'b1;
endtask

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// directed tests
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

task automatic word_round_trip();
    riscv_pkg::word_t a;
    for (int i = 0; i < 64; i++) begin
        a = rand_word_addr();
        step(riscv_pkg::STORE_WORD, a, take_bits(32), rand_fetch_addr());
        step(riscv_pkg::LOAD_WORD, a, '0, rand_fetch_addr());
    end
endtask

task automatic partial_stores();
    riscv_pkg::word_t a;
    for (int i = 0; i < 16; i++) begin
        a = rand_word_addr();
        for (int lane = 0; lane < 4; lane++) begin
            step(riscv_pkg::STORE_BYTE, a + lane, take_bits(32), rand_fetch_addr());
            step(riscv_pkg::LOAD_WORD, a, '0, rand_fetch_addr());
        end
        for (int half = 0; half < 4; half += 2) begin
            step(riscv_pkg::STORE_HALF, a + half, take_bits(32), rand_fetch_addr());
            step(riscv_pkg::LOAD_WORD, a, '0, rand_fetch_addr());
        end
    end
endtask

task automatic load_extension();
    riscv_pkg::word_t a;
    riscv_pkg::word_t d;
    for (int i = 0; i < 8; i++) begin
        a = rand_word_addr();
        d = take_bits(32);
        d = i[0] ? (d | 32'h8080_8080) : (d & 32'h7f7f_7f7f);  // every sign bit set or clear.
        step(riscv_pkg::STORE_WORD, a, d, rand_fetch_addr());
        for (int lane = 0; lane < 4; lane++) begin
            step(riscv_pkg::LOAD_BYTE, a + lane, '0, rand_fetch_addr());
            step(riscv_pkg::LOAD_BYTE_UNSIGNED, a + lane, '0, rand_fetch_addr());
        end
        for (int half = 0; half < 4; half += 2) begin
            step(riscv_pkg::LOAD_HALF, a + half, '0, rand_fetch_addr());
            step(riscv_pkg::LOAD_HALF_UNSIGNED, a + half, '0, rand_fetch_addr());
        end
    end
endtask

task automatic pipelined_loads();
    riscv_pkg::word_t base;
    riscv_pkg::word_t a;
    for (int r = 0; r < 4; r++) begin
        base = rand_word_addr();
        step(riscv_pkg::STORE_WORD, base, take_bits(32), rand_fetch_addr());
        for (int i = 0; i < 8; i++) begin
            a = (base + 4 * i) & ADDR_MASK;
            if (i[0]) begin
                step(riscv_pkg::LOAD_BYTE, a + i[1:0], '0, rand_fetch_addr());
            end else begin
                step(riscv_pkg::LOAD_WORD, a, '0, rand_fetch_addr());
            end
        end
    end
endtask

task automatic fetch_with_data_traffic();
    riscv_pkg::word_t addrs[$];
    riscv_pkg::word_t a;
    for (int i = 0; i < 16; i++) begin
        a = rand_word_addr();
        addrs.push_back(a);
        step(riscv_pkg::STORE_WORD, a, take_bits(32), a);  // same-cycle fetch sees old word.
    end
    foreach (addrs[i]) begin
        for (int off = 0; off < 4; off++) begin
            step(riscv_pkg::LOAD_WORD, rand_word_addr(), '0, addrs[i] + off);
        end
    end
    a = rand_word_addr();
    step(riscv_pkg::STORE_WORD, a, take_bits(32), rand_fetch_addr());
    step(riscv_pkg::LOAD_STORE_NONE, '0, '0, a);
endtask

`endif

//--- tb/tb_memory.sv
// Testbench for the local memory. Directed tests live in memory_tests.svh.
// A word model predicts every load and fetch; the RAM is preloaded first
// since it has no defined contents after reset.

`include "mem_settings.svh"

module tb_memory;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int               DEPTH       = 2 ** `MEM_ADDR_WIDTH;
    localparam riscv_pkg::word_t ADDR_MASK   = (32'd1 << (`MEM_ADDR_WIDTH + 2)) - 32'd1;
    localparam riscv_pkg::word_t LFSR_SEED   = 32'h2440cf73;
    localparam int               WATCHDOG_NS = 100000;

    logic               clk;
    logic               rst_n;
    riscv_pkg::mem_op_t dmem_op;
    riscv_pkg::word_t   dmem_addr;
    riscv_pkg::word_t   dmem_wdata;
    riscv_pkg::word_t   dmem_rdata;
    riscv_pkg::word_t   imem_addr;
    riscv_pkg::word_t   imem_rdata;
    logic               imem_error;

    // model and the results still in flight.
    riscv_pkg::word_t   model_mem [DEPTH];
    riscv_pkg::word_t   lfsr_state;
    logic               memory_known;
    logic               load_pending;
    riscv_pkg::word_t   load_expect;
    string              load_what;
    logic               fetch_pending;
    logic               fetch_data_valid;
    riscv_pkg::word_t   fetch_expect;
    logic               error_expect;
    string              fetch_what;

    memory UUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .dmem_op    (dmem_op),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_rdata (dmem_rdata),
        .imem_addr  (imem_addr),
        .imem_rdata (imem_rdata),
        .imem_error (imem_error)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // random numbers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // taps 32, 22, 2, 1.
    function automatic riscv_pkg::word_t lfsr_next(input riscv_pkg::word_t s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic riscv_pkg::word_t take_bits(input int n);
        riscv_pkg::word_t r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            r = {r[30:0], lfsr_state[0]};  // one step per bit.
        end
        return r;
    endfunction

    `include "memory_tests.svh"

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // clock, reset, watchdog
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the test sequence finished");
        $display("sim failed");
        $fatal(1, "watchdog timeout");
    end

    initial begin
        dmem_op          = riscv_pkg::LOAD_STORE_NONE;
        dmem_addr        = '0;
        dmem_wdata       = '0;
        imem_addr        = 32'h0000_0002;  // misaligned so reset must clear the flag.
        lfsr_state       = LFSR_SEED;
        memory_known     = 1'b0;
        load_pending     = 1'b0;
        fetch_pending    = 1'b0;
        fetch_data_valid = 1'b0;

        wait_reset_release();
        check_equal(imem_error, 1'b0, "imem_error in the cycle after reset");

        preload_memory();
        word_round_trip();
        partial_stores();
        load_extension();
        pipelined_loads();
        fetch_with_data_traffic();
        step(riscv_pkg::LOAD_STORE_NONE, '0, '0, '0);  // drain the last results.

        $display("sim passed");
        $finish;
    end

endmodule

//--- list.f
+incdir+source
+incdir+tb
source/riscv_pkg.sv
source/mem_pkg.sv
source/ram_port_if.sv
source/dual_port_bram.sv
source/data_lane_unit.sv
source/fetch_port.sv
source/memory.sv
tb/tb_memory.sv
